//--- Bender.yml
package:
  name: cam_dma

sources:
  - cam_pkg.sv
  - dma_pkg.sv
  - cmos_capture.sv
  - pixel_word_packer.sv
  - frame_word_fifo.sv
  - dma_read_port.sv
  - link_led_blink.sv
  - cam_dma_top.sv
  - target: test
    files:
      - tb_cam_dma_top.sv

//--- cam_dma_top.sv
//==========================================================================
// Camera to DMA top: capture, packing, word FIFO, read port and link LED,
// all in the pclk_div2 domain
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module cam_dma_top #(
	parameter int LED_CNT_W = 27
) (
	input  wire logic               i_pclk_div2,
	input  wire logic               i_core_rst_n,
	input  wire cam_pkg::cam_byte_t i_cam_data,
	input  wire logic               i_cam_href,
	input  wire logic               i_cam_vsync,
	input  wire logic               i_rd_en,
	output dma_pkg::dma_rd_result_t o_rd,
	output logic                    o_overflow,
	input  wire logic               i_smlh_link_up,
	input  wire logic               i_rdlh_link_up,
	output logic                    o_link_led
);

	import cam_pkg::*;
	import dma_pkg::*;

	cam_sample_t cam_bus;
	pixel_beat_t beat;
	dma_word_t   pack_word;
	logic        pack_wr;
	logic        pack_flush;
	dma_word_t   fifo_head;
	logic        fifo_empty;
	logic        fifo_pop;

	assign cam_bus = '{data: i_cam_data, href: i_cam_href, vsync: i_cam_vsync};

	//==========================================================================
	// Capture path
	//==========================================================================
	cmos_capture u_cmos_capture (
		.i_pclk_div2  (i_pclk_div2),
		.i_core_rst_n (i_core_rst_n),
		.i_cam        (cam_bus),
		.o_beat       (beat)
	);

	pixel_word_packer u_pixel_word_packer (
		.i_pclk_div2  (i_pclk_div2),
		.i_core_rst_n (i_core_rst_n),
		.i_beat       (beat),
		.o_word       (pack_word),
		.o_word_wr    (pack_wr),
		.o_flush      (pack_flush)
	);

	frame_word_fifo u_frame_word_fifo (
		.i_pclk_div2  (i_pclk_div2),
		.i_core_rst_n (i_core_rst_n),
		.i_wr         (pack_wr),
		.i_wr_word    (pack_word),
		.i_flush      (pack_flush),
		.i_pop        (fifo_pop),
		.o_head       (fifo_head),
		.o_empty      (fifo_empty),
		.o_overflow   (o_overflow)
	);

	// Host read side
	dma_read_port u_dma_read_port (
		.i_pclk_div2  (i_pclk_div2),
		.i_core_rst_n (i_core_rst_n),
		.i_rd_en      (i_rd_en),
		.i_head       (fifo_head),
		.i_empty      (fifo_empty),
		.o_pop        (fifo_pop),
		.o_rd         (o_rd)
	);

	link_led_blink #(
		.CNT_W (LED_CNT_W)
	) u_link_led_blink (
		.i_pclk_div2    (i_pclk_div2),
		.i_core_rst_n   (i_core_rst_n),
		.i_smlh_link_up (i_smlh_link_up),
		.i_rdlh_link_up (i_rdlh_link_up),
		.o_led          (o_link_led)
	);

endmodule

`default_nettype wire

//--- cam_pkg.sv
//==========================================================================
// Camera-side types shared by the capture path and the word packer
//==========================================================================
`default_nettype none

package cam_pkg;

	// Bytes that make up one RGB565 pixel on the 8-bit camera bus
	localparam int BYTES_PER_PIXEL = 2;

	// One byte as it arrives on the camera bus
	typedef logic [7:0] cam_byte_t;

	// RGB565 pixel, first byte of the pair in the upper half
	typedef logic [BYTES_PER_PIXEL*$bits(cam_byte_t)-1:0] pixel_t;

	//==========================================================================
	// Bundled camera signals
	//==========================================================================

	// Registered camera bus, 10 bits
	typedef struct packed {
		cam_byte_t data;
		logic      href;   // Line data level
		logic      vsync;  // Frame sync level
	} cam_sample_t;

	// One pixel slot from capture to packer, 18 bits
	typedef struct packed {
		pixel_t pixel;
		logic   valid;        // Pixel carries a completed byte pair
		logic   frame_start;  // vsync rise seen, restart the path
	} pixel_beat_t;

endpackage

`default_nettype wire

//--- cmos_capture.sv
//==========================================================================
// Camera input stage: registers the bus, finds frame start and pairs
// bytes into RGB565 pixels for the word packer
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module cmos_capture (
	input  wire logic                 i_pclk_div2,
	input  wire logic                 i_core_rst_n,
	input  wire cam_pkg::cam_sample_t i_cam,
	output cam_pkg::pixel_beat_t      o_beat
);

	import cam_pkg::*;

	cam_sample_t cam_q;       // Input register stage
	logic        vsync_prev;  // Last registered vsync
	logic        frame_rise;
	logic        byte_phase;  // High while the first byte of a pair is held
	cam_byte_t   first_byte;
	pixel_t      beat_pixel;
	logic        beat_valid;
	logic        beat_fs;

	assign frame_rise = cam_q.vsync & ~vsync_prev;

	//==========================================================================
	// Input register and vsync edge detect
	//==========================================================================
	always_ff @(posedge i_pclk_div2 or negedge i_core_rst_n) begin
		if (!i_core_rst_n) begin
			cam_q      <= '0;
			vsync_prev <= 1'b0;
		end else begin
			cam_q      <= i_cam;
			vsync_prev <= cam_q.vsync;
		end
	end

	//==========================================================================
	// Byte pairing
	//==========================================================================
	always_ff @(posedge i_pclk_div2 or negedge i_core_rst_n) begin
		if (!i_core_rst_n) begin
			byte_phase <= 1'b0;
			beat_valid <= 1'b0;
			beat_fs    <= 1'b0;
		end else begin
			beat_fs    <= frame_rise;
			beat_valid <= 1'b0;
			if (frame_rise) begin
				byte_phase <= 1'b0;  // Drop any half pair
			end else if (cam_q.href) begin
				beat_valid <= byte_phase;  // Second byte completes a pixel
				byte_phase <= ~byte_phase;
			end
		end
	end

	// Pixel data path
	always_ff @(posedge i_pclk_div2) begin
		if (cam_q.href && !byte_phase) begin
			first_byte <= cam_q.data;
		end
		if (cam_q.href && byte_phase) begin
			beat_pixel <= {first_byte, cam_q.data};  // First byte on top
		end
	end

	assign o_beat = '{pixel: beat_pixel, valid: beat_valid, frame_start: beat_fs};

endmodule

`default_nettype wire

//--- dma_pkg.sv
//==========================================================================
// DMA-side word, FIFO sizing and read result used on the host read side
//==========================================================================
`default_nettype none

package dma_pkg;

	localparam int PIXELS_PER_WORD = 8;
	localparam int FIFO_DEPTH      = 16;  // Words buffered on chip
	localparam int FIFO_ADDR_W     = 4;

	// One DMA word, pixel 0 of a group in bits 15:0
	typedef logic [127:0] dma_word_t;

	//==========================================================================
	// Read port result
	//==========================================================================

	// Registered answer to one read enable, 130 bits
	typedef struct packed {
		dma_word_t word;      // Zero on underrun
		logic      valid;     // Word popped from the FIFO
		logic      underrun;  // Read met an empty FIFO
	} dma_rd_result_t;

endpackage

`default_nettype wire

//--- dma_read_port.sv
//==========================================================================
// Host read side: a read enable returns the FIFO head or an underrun
// one cycle later, matching the timing of a synchronous RAM read
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module dma_read_port (
	input  wire logic               i_pclk_div2,
	input  wire logic               i_core_rst_n,
	input  wire logic               i_rd_en,
	input  wire dma_pkg::dma_word_t i_head,
	input  wire logic               i_empty,
	output logic                    o_pop,
	output dma_pkg::dma_rd_result_t o_rd
);

	import dma_pkg::*;

	dma_rd_result_t rd_next;

	assign o_pop = i_rd_en & ~i_empty;  // Pop only what exists

	always_comb begin
		rd_next = '0;
		if (i_rd_en) begin
			rd_next.valid    = ~i_empty;
			rd_next.underrun = i_empty;
			if (!i_empty) begin
				rd_next.word = i_head;
			end
		end
	end

	// One cycle read latency
	always_ff @(posedge i_pclk_div2 or negedge i_core_rst_n) begin
		if (!i_core_rst_n) begin
			o_rd <= '0;
		end else begin
			o_rd <= rd_next;
		end
	end

	a_valid_xor_underrun : assert property (
		@(posedge i_pclk_div2) disable iff (!i_core_rst_n)
		!(o_rd.valid && o_rd.underrun)
	);

endmodule

`default_nettype wire

//--- flist.f
cam_pkg.sv
dma_pkg.sv
cmos_capture.sv
pixel_word_packer.sv
frame_word_fifo.sv
dma_read_port.sv
link_led_blink.sv
cam_dma_top.sv
tb_cam_dma_top.sv

//--- frame_word_fifo.sv
//==========================================================================
// On-chip word FIFO between the packer and the read port; frame start
// empties it and clears the overflow flag
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module frame_word_fifo (
	input  wire logic               i_pclk_div2,
	input  wire logic               i_core_rst_n,
	input  wire logic               i_wr,
	input  wire dma_pkg::dma_word_t i_wr_word,
	input  wire logic               i_flush,
	input  wire logic               i_pop,
	output dma_pkg::dma_word_t      o_head,
	output logic                    o_empty,
	output logic                    o_overflow
);

	import dma_pkg::*;

	dma_word_t              mem [FIFO_DEPTH];
	logic [FIFO_ADDR_W-1:0] wr_ptr;
	logic [FIFO_ADDR_W-1:0] rd_ptr;
	logic [FIFO_ADDR_W:0]   count;  // Occupancy, 0 to FIFO_DEPTH
	logic                   full;
	logic                   wr_ok;
	logic                   pop_ok;

	assign full    = (count == (FIFO_ADDR_W+1)'(FIFO_DEPTH));
	assign o_empty = (count == '0);
	assign wr_ok   = i_wr & ~full & ~i_flush;    // Flush wins over a write
	assign pop_ok  = i_pop & ~o_empty & ~i_flush;
	assign o_head  = mem[rd_ptr];

	always_ff @(posedge i_pclk_div2) begin
		if (wr_ok) begin
			mem[wr_ptr] <= i_wr_word;
		end
	end

	//==========================================================================
	// Pointers, occupancy and overflow
	//==========================================================================
	always_ff @(posedge i_pclk_div2 or negedge i_core_rst_n) begin
		if (!i_core_rst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			o_overflow <= 1'b0;
		end else if (i_flush) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			o_overflow <= 1'b0;
		end else begin
			if (wr_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_ok, pop_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			if (i_wr && full) begin
				o_overflow <= 1'b1;  // Sticky until next frame start
			end
		end
	end

	a_count_bound : assert property (
		@(posedge i_pclk_div2) disable iff (!i_core_rst_n)
		count <= (FIFO_ADDR_W+1)'(FIFO_DEPTH)
	);

	// The read port must only pop a word that is there
	a_no_pop_empty : assert property (
		@(posedge i_pclk_div2) disable iff (!i_core_rst_n)
		i_pop |-> !o_empty
	);

endmodule

`default_nettype wire

//--- link_led_blink.sv
//==========================================================================
// Link status LED: toggles each time the counter wraps while link is up
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module link_led_blink #(
	parameter int CNT_W = 27  // Toggle every 2**CNT_W enabled cycles
) (
	input  wire logic i_pclk_div2,
	input  wire logic i_core_rst_n,
	input  wire logic i_smlh_link_up,
	input  wire logic i_rdlh_link_up,
	output logic      o_led
);

	logic [CNT_W-1:0] blink_cnt;
	logic             link_up;

	assign link_up = i_smlh_link_up & i_rdlh_link_up;

	always_ff @(posedge i_pclk_div2 or negedge i_core_rst_n) begin
		if (!i_core_rst_n) begin
			blink_cnt <= '0;
			o_led     <= 1'b1;  // LED starts lit
		end else if (link_up) begin
			blink_cnt <= blink_cnt + 1'b1;
			if (&blink_cnt) begin
				o_led <= ~o_led;  // All ones to zero
			end
		end
	end

endmodule

`default_nettype wire

//--- pixel_word_packer.sv
//==========================================================================
// Gathers eight pixels into one 128-bit DMA word and forwards frame start
// as a flush that stays in step with the word strobe
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module pixel_word_packer (
	input  wire logic                 i_pclk_div2,
	input  wire logic                 i_core_rst_n,
	input  wire cam_pkg::pixel_beat_t i_beat,
	output dma_pkg::dma_word_t        o_word,
	output logic                      o_word_wr,
	output logic                      o_flush
);

	import cam_pkg::*;
	import dma_pkg::*;

	localparam int CNT_W = $clog2(PIXELS_PER_WORD);

	logic [CNT_W-1:0] pix_cnt;  // Pixels already in the group
	dma_word_t        shift_q;

	// New pixels enter at the top, so pixel 0 ends in bits 15:0
	always_ff @(posedge i_pclk_div2) begin
		if (i_beat.valid) begin
			shift_q <= {i_beat.pixel, shift_q[$bits(dma_word_t)-1:$bits(pixel_t)]};
		end
	end

	assign o_word = shift_q;

	//==========================================================================
	// Group count and strobes
	//==========================================================================
	always_ff @(posedge i_pclk_div2 or negedge i_core_rst_n) begin
		if (!i_core_rst_n) begin
			pix_cnt   <= '0;
			o_word_wr <= 1'b0;
			o_flush   <= 1'b0;
		end else begin
			o_flush   <= i_beat.frame_start;
			o_word_wr <= 1'b0;
			if (i_beat.frame_start) begin
				pix_cnt <= '0;  // Partial group is discarded
			end else if (i_beat.valid) begin
				pix_cnt   <= pix_cnt + 1'b1;  // Wraps after the eighth pixel
				o_word_wr <= (pix_cnt == CNT_W'(PIXELS_PER_WORD - 1));
			end
		end
	end

	// Capture never emits a pixel in its frame-start cycle
	a_beat_exclusive : assert property (
		@(posedge i_pclk_div2) disable iff (!i_core_rst_n)
		!(i_beat.valid && i_beat.frame_start)
	);

endmodule

`default_nettype wire

//--- tb_cam_dma_top.sv
//==========================================================================
// Self-checking testbench for the camera to DMA top: random camera lines
// and reads checked against a byte level model of pairing and packing
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module tb_cam_dma_top;

	import cam_pkg::*;
	import dma_pkg::*;

	localparam int CLK_PERIOD   = 100;
	localparam int LED_CNT_W    = 4;
	localparam int SETTLE       = 8;   // Idle cycles before reads
	localparam int READ_CYC     = 3;
	localparam int GAP_MAX      = 3;
	localparam int LINES        = 5;
	localparam int LED_STEPS    = 200;
	localparam int LINE_CYC     = 48*(GAP_MAX+1) + SETTLE + 4*(GAP_MAX+READ_CYC);
	localparam int TOTAL_CYC    = 20 + (32+SETTLE+2*READ_CYC) + LINES*LINE_CYC
		+ 2*READ_CYC + (288+SETTLE+17*READ_CYC) + 100 + LED_STEPS + 2;
	localparam int WATCHDOG_CYC = TOTAL_CYC + TOTAL_CYC/4 + 100;

	logic           pclk_div2;
	logic           core_rst_n;
	cam_byte_t      cam_data;
	logic           cam_href;
	logic           cam_vsync;
	logic           rd_en;
	dma_rd_result_t rd;
	logic           overflow;
	logic           smlh_link_up;
	logic           rdlh_link_up;
	logic           link_led;

	integer    seed;
	int        n_checks;
	int        n_errors;
	int        errors_at_start;

	// Reference model state
	dma_word_t model_q[$];
	dma_word_t model_group;
	int        model_cnt;
	logic      model_phase;
	cam_byte_t model_first;
	logic      model_ovf;
	logic      model_vs;

	cam_dma_top #(.LED_CNT_W(LED_CNT_W)) dut0 (
		.i_pclk_div2    (pclk_div2),
		.i_core_rst_n   (core_rst_n),
		.i_cam_data     (cam_data),
		.i_cam_href     (cam_href),
		.i_cam_vsync    (cam_vsync),
		.i_rd_en        (rd_en),
		.o_rd           (rd),
		.o_overflow     (overflow),
		.i_smlh_link_up (smlh_link_up),
		.i_rdlh_link_up (rdlh_link_up),
		.o_link_led     (link_led)
	);

	initial begin
		pclk_div2 = 1'b0;
		forever #(CLK_PERIOD/2) pclk_div2 = ~pclk_div2;
	end

	//==========================================================================
	// Reference model and stimulus helpers
	//==========================================================================
	function automatic int rand_below(input int n);
		return ($random(seed) & 32'h7fff_ffff) % n;
	endfunction

	function automatic cam_byte_t rand_byte();
		return cam_byte_t'($random(seed));
	endfunction

	// Byte as the DUT sees it, in arrival order
	function automatic void model_byte(input cam_byte_t data, input logic href,
		input logic vsync);
		if (vsync && !model_vs) begin
			model_q.delete();  // Frame start restarts everything
			model_cnt   = 0;
			model_phase = 1'b0;
			model_ovf   = 1'b0;
		end else if (href) begin
			if (!model_phase) begin
				model_first = data;
			end else begin
				// Pixel n of a group goes to bits 16n+15:16n
				model_group[model_cnt*$bits(pixel_t) +: $bits(pixel_t)] = {model_first, data};
				model_cnt++;
				if (model_cnt == PIXELS_PER_WORD) begin
					if (model_q.size() < FIFO_DEPTH) model_q.push_back(model_group);
					else model_ovf = 1'b1;
					model_cnt = 0;
				end
			end
			model_phase = !model_phase;
		end
		model_vs = vsync;
	endfunction

	task automatic drive_cycle(input cam_byte_t data, input logic href, input logic vsync);
		@(posedge pclk_div2);
		cam_data  <= data;
		cam_href  <= href;
		cam_vsync <= vsync;
		model_byte(data, href, vsync);
	endtask

	task automatic settle(input int n);
		repeat (n) drive_cycle(rand_byte(), 1'b0, 1'b0);
	endtask

	task automatic send_line(input int n_bytes, input int gap_max);
		for (int i = 0; i < n_bytes; i++) begin
			if (gap_max > 0) settle(rand_below(gap_max + 1));
			drive_cycle(rand_byte(), 1'b1, 1'b0);
		end
	endtask

	//==========================================================================
	// Compare tasks
	//==========================================================================
	task automatic check_rd(input dma_rd_result_t got, input dma_rd_result_t exp);
		n_checks++;
		if (got.valid && got.underrun) begin
			n_errors++;
			$display("o_rd has valid and underrun high together at %0t", $time);
		end else if (got !== exp) begin
			n_errors++;
			$display("Error at %0t: o_rd expected word %h v %b u %b, got word %h v %b u %b",
				$time, exp.word, exp.valid, exp.underrun, got.word, got.valid, got.underrun);
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Error at %0t: %s expected %b, got %b", $time, name, exp, got);
		end
	endtask

	// One read enable, answer checked one cycle later
	task automatic read_and_check();
		dma_rd_result_t exp;
		exp = '0;
		if (model_q.size() > 0) begin
			exp.word  = model_q.pop_front();
			exp.valid = 1'b1;
		end else begin
			exp.underrun = 1'b1;
		end
		@(posedge pclk_div2);
		rd_en <= 1'b1;
		@(posedge pclk_div2);
		rd_en <= 1'b0;
		@(negedge pclk_div2);
		check_rd(rd, exp);
	endtask

	task automatic end_test(input int num, input string name);
		int errs;
		errs = n_errors - errors_at_start;
		if (errs == 0) $display("test %0d (%s): ok", num, name);
		else $display("test %0d (%s): %0d errors", num, name, errs);
		errors_at_start = n_errors;
	endtask

	//==========================================================================
	// Test sequence
	//==========================================================================
	initial begin
		logic cur_s;
		logic cur_r;
		logic model_led;
		int   led_cnt;
		seed = 32'hb9b35d4c;
		n_checks = 0;
		n_errors = 0;
		errors_at_start = 0;
		model_group = '0;
		model_cnt = 0;
		model_phase = 1'b0;
		model_first = '0;
		model_ovf = 1'b0;
		model_vs = 1'b0;
		core_rst_n = 1'b0;
		cam_data = '0;
		cam_href = 1'b0;
		cam_vsync = 1'b0;
		rd_en = 1'b0;
		smlh_link_up = 1'b0;
		rdlh_link_up = 1'b0;
		repeat (16) @(posedge pclk_div2);
		core_rst_n <= 1'b1;
		@(negedge pclk_div2);
		check_rd(rd, '0);
		check_level("o_overflow", overflow, 1'b0);
		check_level("o_link_led", link_led, 1'b1);  // Lit out of reset

		send_line(32, 0);
		settle(SETTLE);
		repeat (2) read_and_check();
		end_test(1, "pixel packing and order");

		for (int l = 0; l < LINES; l++) begin
			send_line(8 * (2 + rand_below(5)), GAP_MAX);
			settle(SETTLE);
			while (model_q.size() > 0) begin
				settle(rand_below(GAP_MAX + 1));
				read_and_check();
			end
		end
		@(negedge pclk_div2);
		check_level("o_overflow", overflow, model_ovf);
		end_test(2, "random reads between lines");

		repeat (2) read_and_check();
		end_test(3, "underrun");

		send_line(18 * 16, 0);  // 18 words, two dropped
		settle(SETTLE);
		@(negedge pclk_div2);
		check_level("o_overflow", overflow, 1'b1);
		check_level("o_overflow", overflow, model_ovf);
		repeat (FIFO_DEPTH + 1) read_and_check();
		end_test(4, "overflow");

		send_line(21, 0);  // One word plus a partial group
		settle(SETTLE);
		repeat (2) drive_cycle(rand_byte(), 1'b0, 1'b1);
		settle(SETTLE);
		@(negedge pclk_div2);
		check_level("o_overflow", overflow, 1'b0);
		read_and_check();
		send_line(32, 0);
		settle(SETTLE);
		repeat (2) read_and_check();
		end_test(5, "frame start");

		check_level("o_link_led", link_led, 1'b1);
		model_led = 1'b1;
		led_cnt = 0;
		cur_s = 1'b0;
		cur_r = 1'b0;
		for (int i = 0; i <= LED_STEPS; i++) begin
			@(posedge pclk_div2);
			// Levels driven last step are sampled at this edge
			if (cur_s && cur_r) begin
				if (led_cnt == (1 << LED_CNT_W) - 1) model_led = ~model_led;
				led_cnt = (led_cnt + 1) % (1 << LED_CNT_W);
			end
			cur_s = (i < LED_STEPS) ? (rand_below(4) != 0) : 1'b0;
			cur_r = (i < LED_STEPS) ? (rand_below(4) != 0) : 1'b0;
			smlh_link_up <= cur_s;
			rdlh_link_up <= cur_r;
			@(negedge pclk_div2);
			check_level("o_link_led", link_led, model_led);
		end
		end_test(6, "LED blinking");

		$display("Checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Bound on the whole run
	initial begin
		#(WATCHDOG_CYC * CLK_PERIOD);
		$display("Watchdog expired before all tests finished");
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire
